// File: sources.f
+incdir+.
decode_pkg.sv
fetch_decode_if.sv
fetch_stage_reg.sv
decoder.sv
instr_fifo.sv
decode_top.sv
tb_decode.sv

// File: run.sh
#!/bin/bash
# build with Verilator, run, then judge the run by its log
verilator --binary --timing --timescale 1ns/1ns -f sources.f --top-module tb_decode \
	-o tb_decode_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_decode_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// File: decode_model.svh
// testbench reference decoder built from the RV64I encoding tables
// random instruction generator drawing from the testbench seed variable
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected micro-instruction for one instruction word
function automatic decode_pkg::decode_info_t ref_decode(logic [31:0] w, logic [63:0] w_pc);
	decode_pkg::decode_info_t d;
	decode_pkg::op_e br_ops [8];
	decode_pkg::op_e ld_ops [8];
	decode_pkg::op_e st_ops [4];
	decode_pkg::op_e alui_ops [8];
	decode_pkg::op_e alu_ops [8];
	decode_pkg::op_e csr_ops [8];
	logic [2:0] f3;
	logic [6:0] f7;
	logic [7:0] kind;
	br_ops = '{decode_pkg::op_beq, decode_pkg::op_bne, decode_pkg::op_illegal,
		decode_pkg::op_illegal, decode_pkg::op_blt, decode_pkg::op_bge,
		decode_pkg::op_bltu, decode_pkg::op_bgeu};
	ld_ops = '{decode_pkg::op_lb, decode_pkg::op_lh, decode_pkg::op_lw, decode_pkg::op_ld,
		decode_pkg::op_lbu, decode_pkg::op_lhu, decode_pkg::op_lwu, decode_pkg::op_illegal};
	st_ops = '{decode_pkg::op_sb, decode_pkg::op_sh, decode_pkg::op_sw, decode_pkg::op_sd};
	// index 1 and 5 are the shifts and are decoded separately
	alui_ops = '{decode_pkg::op_addi, decode_pkg::op_illegal, decode_pkg::op_slti,
		decode_pkg::op_sltiu, decode_pkg::op_xori, decode_pkg::op_illegal,
		decode_pkg::op_ori, decode_pkg::op_andi};
	alu_ops = '{decode_pkg::op_add, decode_pkg::op_sll, decode_pkg::op_slt, decode_pkg::op_sltu,
		decode_pkg::op_xor, decode_pkg::op_srl, decode_pkg::op_or, decode_pkg::op_and};
	csr_ops = '{decode_pkg::op_illegal, decode_pkg::op_csrrw, decode_pkg::op_csrrs,
		decode_pkg::op_csrrc, decode_pkg::op_illegal, decode_pkg::op_csrrwi,
		decode_pkg::op_csrrsi, decode_pkg::op_csrrci};
	f3 = w[14:12];
	f7 = w[31:25];
	d = '0;
	d.op = decode_pkg::op_illegal;
	d.pc = w_pc;
	d.shamt = w[25:20];
	d.rd = w[11:7];
	d.rs1 = w[19:15];
	d.rs2 = w[24:20];
	case (w[6:0])
		7'h37: d.op = decode_pkg::op_lui;
		7'h17: d.op = decode_pkg::op_auipc;
		7'h6f: d.op = decode_pkg::op_jal;
		7'h67: d.op = (f3 == 3'd0) ? decode_pkg::op_jalr : decode_pkg::op_illegal;
		7'h63: d.op = br_ops[f3];
		7'h03: d.op = ld_ops[f3];
		7'h23: d.op = f3[2] ? decode_pkg::op_illegal : st_ops[f3[1:0]];
		7'h0f: begin
			if (f3 == 3'd0)
				d.op = decode_pkg::op_fence;
			else if (f3 == 3'd1)
				d.op = decode_pkg::op_fence_i;
		end
		7'h13: begin
			// funct6 selects the shift since the rv64 shift amount is six bits wide
			if (f3 == 3'd1 && w[31:26] == 6'h00)
				d.op = decode_pkg::op_slli;
			else if (f3 == 3'd5 && w[31:26] == 6'h00)
				d.op = decode_pkg::op_srli;
			else if (f3 == 3'd5 && w[31:26] == 6'h10)
				d.op = decode_pkg::op_srai;
			else if (f3 != 3'd1 && f3 != 3'd5)
				d.op = alui_ops[f3];
		end
		7'h1b: begin
			if (f3 == 3'd0)
				d.op = decode_pkg::op_addiw;
			else if (f3 == 3'd1 && f7 == 7'h00)
				d.op = decode_pkg::op_slliw;
			else if (f3 == 3'd5 && f7 == 7'h00)
				d.op = decode_pkg::op_srliw;
			else if (f3 == 3'd5 && f7 == 7'h20)
				d.op = decode_pkg::op_sraiw;
		end
		7'h33: begin
			if (f7 == 7'h00)
				d.op = alu_ops[f3];
			else if (f7 == 7'h20 && f3 == 3'd0)
				d.op = decode_pkg::op_sub;
			else if (f7 == 7'h20 && f3 == 3'd5)
				d.op = decode_pkg::op_sra;
		end
		7'h3b: begin
			if (f7 == 7'h00 && f3 == 3'd0)
				d.op = decode_pkg::op_addw;
			else if (f7 == 7'h00 && f3 == 3'd1)
				d.op = decode_pkg::op_sllw;
			else if (f7 == 7'h00 && f3 == 3'd5)
				d.op = decode_pkg::op_srlw;
			else if (f7 == 7'h20 && f3 == 3'd0)
				d.op = decode_pkg::op_subw;
			else if (f7 == 7'h20 && f3 == 3'd5)
				d.op = decode_pkg::op_sraw;
		end
		7'h73: begin
			if (f3 != 3'd0)
				d.op = csr_ops[f3];
			else if (w[31:20] == 12'h000)
				d.op = decode_pkg::op_ecall;
			else if (w[31:20] == 12'h001)
				d.op = decode_pkg::op_ebreak;
		end
		default: d.op = decode_pkg::op_illegal;
	endcase
	// immediate format follows the major opcode
	case (w[6:0])
		7'h37, 7'h17: kind = "u";
		7'h6f:        kind = "j";
		7'h63:        kind = "b";
		7'h23:        kind = "s";
		7'h67, 7'h03, 7'h0f, 7'h13, 7'h1b, 7'h73: kind = "i";
		default:      kind = "-";
	endcase
	// shift amounts travel in shamt
	if ((w[6:0] == 7'h13 || w[6:0] == 7'h1b) && f3[1:0] == 2'b01)
		kind = "-";
	// ecall and ebreak keep no immediate
	if (w[6:0] == 7'h73 && f3 == 3'd0)
		kind = "-";
	if (d.op == decode_pkg::op_illegal)
		kind = "-";
	case (kind)
		"i":     d.imm = 64'($signed(w[31:20]));
		"s":     d.imm = 64'($signed({w[31:25], w[11:7]}));
		"b":     d.imm = 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
		"u":     d.imm = 64'($signed({w[31:12], 12'h000}));
		"j":     d.imm = 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
		default: d.imm = 64'd0;
	endcase
	return d;
endfunction

// random instruction word that is illegal in about one draw of ten
function automatic logic [31:0] gen_instr();
	logic [31:0] w;
	w = $random(seed);
	if ($unsigned($random(seed)) % 10 == 0) begin
		case (w[9:8])
			2'd0: w[1:0] = 2'b00;
			2'd1: begin
				w[14:12] = 3'b010;
				w[6:0] = 7'h63;
			end
			2'd2: begin
				w[31:25] = 7'h01;
				w[6:0] = 7'h33;
			end
			default: begin
				w[14:12] = 3'b100;
				w[6:0] = 7'h73;
			end
		endcase
		return w;
	end
	case ($unsigned($random(seed)) % 14)
		0: w[6:0] = 7'h37;
		1: w[6:0] = 7'h17;
		2: w[6:0] = 7'h6f;
		3: begin
			w[14:12] = 3'b000;
			w[6:0] = 7'h67;
		end
		4: begin
			if (w[14:13] == 2'b01)
				w[14] = 1'b1;
			w[6:0] = 7'h63;
		end
		5: begin
			if (w[14:12] == 3'b111)
				w[14] = 1'b0;
			w[6:0] = 7'h03;
		end
		6: begin
			w[14] = 1'b0;
			w[6:0] = 7'h23;
		end
		7: begin
			if (w[14:12] == 3'b001)
				w[31:26] = 6'h00;
			if (w[14:12] == 3'b101)
				w[31:26] = {1'b0, w[30], 4'b0000};
			w[6:0] = 7'h13;
		end
		8, 10: begin
			// funct3 limited to 000, 001 and 101
			w[14:12] = w[13] ? 3'b000 : {w[14], 2'b01};
			// op-32 add and sub need funct7 of 0x00 or 0x20
			if (w[12])
				w[31:25] = {1'b0, w[30] & w[14], 5'b00000};
			else if (!w[4])
				w[31:25] = {1'b0, w[30], 5'b00000};
			w[6:0] = w[4] ? 7'h1b : 7'h3b;
		end
		9: begin
			if (w[30] && (w[14:12] == 3'b000 || w[14:12] == 3'b101))
				w[31:25] = 7'h20;
			else
				w[31:25] = 7'h00;
			w[6:0] = 7'h33;
		end
		11: begin
			w[14:13] = 2'b00;
			w[6:0] = 7'h0f;
		end
		12: begin
			w[31:21] = 11'h000;
			w[14:12] = 3'b000;
			w[6:0] = 7'h73;
		end
		default: begin
			if (w[13:12] == 2'b00)
				w[12] = 1'b1;
			w[6:0] = 7'h73;
		end
	endcase
	return w;
endfunction

`endif

// File: tb_decode.sv
// testbench for the decode slice
// random instructions against a reference decoder, scoreboard queue and watchdog
`timescale 1ns/1ns

module tb_decode;

	localparam int num_instr       = 450;
	localparam int watchdog_cycles = num_instr * 8 + 100;

	logic            clk;
	logic            reset;
	logic            instr_valid;
	logic [31:0]     instr;
	logic [63:0]     pc;
	logic            fetch_ready;
	logic            issue_pop;
	logic            issue_valid;
	decode_pkg::op_e issue_op;
	logic [63:0]     issue_pc;
	logic [63:0]     issue_imm;
	logic [5:0]      issue_shamt;
	logic [4:0]      issue_rd;
	logic [4:0]      issue_rs1;
	logic [4:0]      issue_rs2;

	int    seed;
	int    errors;
	int    n_sent;
	int    n_popped;
	int    stall;
	string phase;
	// occupancy model of the fetch register and the FIFO
	int    fifo_cnt;
	logic  fetch_occ;
	decode_pkg::decode_info_t exp_q [$];

	`include "decode_model.svh"

	decode_top u_dut (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.fetch_ready (fetch_ready),
		.issue_pop   (issue_pop),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_pc    (issue_pc),
		.issue_imm   (issue_imm),
		.issue_shamt (issue_shamt),
		.issue_rd    (issue_rd),
		.issue_rs1   (issue_rs1),
		.issue_rs2   (issue_rs2)
	);

	always #10 clk = ~clk;

	task automatic check(string name, logic [63:0] exp, logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s %s: expected %0h, actual %0h", phase, name, exp, act);
		end
	endtask

	task automatic compare_head();
		decode_pkg::decode_info_t e;
		if (exp_q.size() == 0) begin
			errors++;
			$display("an instruction was popped that was never sent");
		end else begin
			e = exp_q.pop_front();
			n_popped++;
			check("op", 64'(e.op), 64'(issue_op));
			check("pc", e.pc, issue_pc);
			check("imm", e.imm, issue_imm);
			check("shamt", 64'(e.shamt), 64'(issue_shamt));
			check("rd", 64'(e.rd), 64'(issue_rd));
			check("rs1", 64'(e.rs1), 64'(issue_rs1));
			check("rs2", 64'(e.rs2), 64'(issue_rs2));
		end
	endtask

	task automatic drive_instr();
		instr = gen_instr();
		pc = {$random(seed), $random(seed)};
		pc[1:0] = 2'b00;
		instr_valid = 1'b1;
	endtask

	// inputs for the next rising edge are driven, outputs are stable here
	task automatic step();
		logic exp_ready;
		logic push_m;
		logic pop_m;
		exp_ready = ~(fetch_occ && fifo_cnt == decode_pkg::instr_fifo_depth);
		check("fetch_ready", 64'(exp_ready), 64'(fetch_ready));
		check("issue_valid", 64'(fifo_cnt != 0), 64'(issue_valid));
		if (issue_valid && issue_pop)
			compare_head();
		if (instr_valid && fetch_ready) begin
			exp_q.push_back(ref_decode(instr, pc));
			n_sent++;
		end
		push_m = fetch_occ && fifo_cnt < decode_pkg::instr_fifo_depth;
		pop_m = issue_pop && fifo_cnt > 0;
		if (push_m)
			fifo_cnt++;
		if (pop_m)
			fifo_cnt--;
		fetch_occ = (instr_valid && fetch_ready) || (fetch_occ && !push_m);
		@(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		issue_pop = 1'b0;
		seed = 32'hc007_7f26;
		errors = 0;
		n_sent = 0;
		n_popped = 0;
		stall = 0;
		fifo_cnt = 0;
		fetch_occ = 1'b0;
		phase = "reset";
		repeat (8) begin
			@(posedge clk);
			@(negedge clk);
			check("issue_valid", 64'd0, 64'(issue_valid));
			check("fetch_ready", 64'd1, 64'(fetch_ready));
		end
		reset = 1'b0;

		// one instruction into an empty pipe, visible after the second edge
		phase = "latency";
		drive_instr();
		step();
		instr_valid = 1'b0;
		step();
		check("issue_valid", 64'd1, 64'(issue_valid));

		phase = "random";
		while (n_sent < num_instr) begin
			if (fetch_ready && $unsigned($random(seed)) % 4 != 0)
				drive_instr();
			else
				instr_valid = 1'b0;
			// long pop stalls fill the FIFO and back up the fetch register
			if (stall > 0) begin
				stall--;
				issue_pop = 1'b0;
			end else if ($unsigned($random(seed)) % 12 == 0) begin
				stall = 6 + $unsigned($random(seed)) % 10;
				issue_pop = 1'b0;
			end else begin
				issue_pop = ($unsigned($random(seed)) % 4 != 0);
			end
			step();
		end

		phase = "drain";
		instr_valid = 1'b0;
		issue_pop = 1'b1;
		while (fifo_cnt != 0 || fetch_occ)
			step();
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d instructions were sent but never came out", exp_q.size());
		end
		$display("sent %0d, popped %0d, errors %0d", n_sent, n_popped, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: decode_top.sv
// decode slice top level
// fetch register, decoder and instruction FIFO with plain issue ports
`timescale 1ns/1ns

module decode_top (
	input  logic            clk,
	input  logic            reset,
	input  logic            instr_valid,
	input  logic [31:0]     instr,
	input  logic [63:0]     pc,
	output logic            fetch_ready,
	input  logic            issue_pop,
	output logic            issue_valid,
	output decode_pkg::op_e issue_op,
	output logic [63:0]     issue_pc,
	output logic [63:0]     issue_imm,
	output logic [5:0]      issue_shamt,
	output logic [4:0]      issue_rd,
	output logic [4:0]      issue_rs1,
	output logic [4:0]      issue_rs2
);

	fetch_decode_if fd ();

	decode_pkg::decode_info_t micro_instr;
	decode_pkg::decode_info_t head;
	logic                     push;
	logic                     full;

	fetch_stage_reg u_fetch (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.fetch_ready (fetch_ready),
		.fd          (fd.producer)
	);

	decoder u_decoder (
		.fd          (fd.consumer),
		.full        (full),
		.micro_instr (micro_instr),
		.push        (push)
	);

	instr_fifo u_instr_fifo (
		.clk       (clk),
		.reset     (reset),
		.push      (push),
		.push_data (micro_instr),
		.full      (full),
		.pop       (issue_pop),
		.pop_data  (head),
		.pop_valid (issue_valid)
	);

	// head of the FIFO onto the issue ports
	assign issue_op    = head.op;
	assign issue_pc    = head.pc;
	assign issue_imm   = head.imm;
	assign issue_shamt = head.shamt;
	assign issue_rd    = head.rd;
	assign issue_rs1   = head.rs1;
	assign issue_rs2   = head.rs2;

endmodule

// File: instr_fifo.sv
// micro-instruction FIFO
// circular buffer with read / write pointers and an occupancy count
`timescale 1ns/1ns

module instr_fifo (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     push,
	input  decode_pkg::decode_info_t push_data,
	output logic                     full,
	input  logic                     pop,
	output decode_pkg::decode_info_t pop_data,
	output logic                     pop_valid
);

	decode_pkg::decode_info_t mem [decode_pkg::instr_fifo_depth];

	logic [decode_pkg::instr_fifo_aw-1:0] wr_ptr;
	logic [decode_pkg::instr_fifo_aw-1:0] rd_ptr;
	logic [decode_pkg::instr_fifo_aw:0]   count;
	logic                                 pop_en;

	assign full      = (count == (decode_pkg::instr_fifo_aw + 1)'(decode_pkg::instr_fifo_depth));
	assign pop_valid = (count != '0);
	assign pop_data  = mem[rd_ptr];

	// a pop on an empty FIFO is ignored
	assign pop_en = pop & pop_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// depth is a power of two, pointers wrap on their own
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

// File: decoder.sv
// combinational RV64I / Zifencei / Zicsr decoder
// field split, opcode classification, immediate build and FIFO push
`timescale 1ns/1ns

module decoder (
	fetch_decode_if.consumer           fd,
	input  logic                       full,
	output decode_pkg::decode_info_t   micro_instr,
	output logic                       push
);

	// major opcode groups, low two bits always 2'b11
	typedef enum logic [6:0] {
		maj_load     = 7'b0000011,
		maj_misc_mem = 7'b0001111,
		maj_op_imm   = 7'b0010011,
		maj_auipc    = 7'b0010111,
		maj_op_imm32 = 7'b0011011,
		maj_store    = 7'b0100011,
		maj_op       = 7'b0110011,
		maj_lui      = 7'b0110111,
		maj_op_32    = 7'b0111011,
		maj_branch   = 7'b1100011,
		maj_jalr     = 7'b1100111,
		maj_jal      = 7'b1101111,
		maj_system   = 7'b1110011
	} major_e;

	typedef enum logic [2:0] {
		imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
	} imm_sel_e;

	logic [6:0]        opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	logic [4:0]        rd;
	logic [4:0]        rs1;
	logic [4:0]        rs2;
	logic [31:0]       ins;
	decode_pkg::op_e   op;
	imm_sel_e          imm_sel;
	logic [63:0]       imm;

	assign ins    = fd.instr;
	assign opcode = ins[6:0];
	assign rd     = ins[11:7];
	assign funct3 = ins[14:12];
	assign rs1    = ins[19:15];
	assign rs2    = ins[24:20];
	assign funct7 = ins[31:25];

	// shift-immediates carry their amount in shamt, so they keep imm_none
	always_comb begin
		op      = decode_pkg::op_illegal;
		imm_sel = imm_none;
		case (opcode)
			maj_lui: begin
				op = decode_pkg::op_lui; imm_sel = imm_u;
			end
			maj_auipc: begin
				op = decode_pkg::op_auipc; imm_sel = imm_u;
			end
			maj_jal: begin
				op = decode_pkg::op_jal; imm_sel = imm_j;
			end
			maj_jalr: begin
				if (funct3 == 3'b000) begin
					op = decode_pkg::op_jalr; imm_sel = imm_i;
				end
			end
			maj_branch: begin
				imm_sel = imm_b;
				case (funct3)
					3'b000:  op = decode_pkg::op_beq;
					3'b001:  op = decode_pkg::op_bne;
					3'b100:  op = decode_pkg::op_blt;
					3'b101:  op = decode_pkg::op_bge;
					3'b110:  op = decode_pkg::op_bltu;
					3'b111:  op = decode_pkg::op_bgeu;
					default: imm_sel = imm_none;
				endcase
			end
			maj_load: begin
				imm_sel = imm_i;
				case (funct3)
					3'b000:  op = decode_pkg::op_lb;
					3'b001:  op = decode_pkg::op_lh;
					3'b010:  op = decode_pkg::op_lw;
					3'b011:  op = decode_pkg::op_ld;
					3'b100:  op = decode_pkg::op_lbu;
					3'b101:  op = decode_pkg::op_lhu;
					3'b110:  op = decode_pkg::op_lwu;
					default: imm_sel = imm_none;
				endcase
			end
			maj_store: begin
				imm_sel = imm_s;
				case (funct3)
					3'b000:  op = decode_pkg::op_sb;
					3'b001:  op = decode_pkg::op_sh;
					3'b010:  op = decode_pkg::op_sw;
					3'b011:  op = decode_pkg::op_sd;
					default: imm_sel = imm_none;
				endcase
			end
			maj_op_imm: begin
				case (funct3)
					3'b000: begin op = decode_pkg::op_addi;  imm_sel = imm_i; end
					3'b010: begin op = decode_pkg::op_slti;  imm_sel = imm_i; end
					3'b011: begin op = decode_pkg::op_sltiu; imm_sel = imm_i; end
					3'b100: begin op = decode_pkg::op_xori;  imm_sel = imm_i; end
					3'b110: begin op = decode_pkg::op_ori;   imm_sel = imm_i; end
					3'b111: begin op = decode_pkg::op_andi;  imm_sel = imm_i; end
					// rv64 shifts use a 6-bit shamt, so only funct7[6:1] is checked
					3'b001: if (funct7[6:1] == 6'b000000) op = decode_pkg::op_slli;
					default: begin
						if (funct7[6:1] == 6'b000000)
							op = decode_pkg::op_srli;
						else if (funct7[6:1] == 6'b010000)
							op = decode_pkg::op_srai;
					end
				endcase
			end
			maj_op_imm32: begin
				case ({funct7, funct3})
					10'b0000000_001: op = decode_pkg::op_slliw;
					10'b0000000_101: op = decode_pkg::op_srliw;
					10'b0100000_101: op = decode_pkg::op_sraiw;
					default: begin
						if (funct3 == 3'b000) begin
							op = decode_pkg::op_addiw; imm_sel = imm_i;
						end
					end
				endcase
			end
			maj_op: begin
				case ({funct7, funct3})
					10'b0000000_000: op = decode_pkg::op_add;
					10'b0100000_000: op = decode_pkg::op_sub;
					10'b0000000_001: op = decode_pkg::op_sll;
					10'b0000000_010: op = decode_pkg::op_slt;
					10'b0000000_011: op = decode_pkg::op_sltu;
					10'b0000000_100: op = decode_pkg::op_xor;
					10'b0000000_101: op = decode_pkg::op_srl;
					10'b0100000_101: op = decode_pkg::op_sra;
					10'b0000000_110: op = decode_pkg::op_or;
					10'b0000000_111: op = decode_pkg::op_and;
					default:         op = decode_pkg::op_illegal;
				endcase
			end
			maj_op_32: begin
				case ({funct7, funct3})
					10'b0000000_000: op = decode_pkg::op_addw;
					10'b0100000_000: op = decode_pkg::op_subw;
					10'b0000000_001: op = decode_pkg::op_sllw;
					10'b0000000_101: op = decode_pkg::op_srlw;
					10'b0100000_101: op = decode_pkg::op_sraw;
					default:         op = decode_pkg::op_illegal;
				endcase
			end
			maj_misc_mem: begin
				if (funct3 == 3'b000) begin
					op = decode_pkg::op_fence; imm_sel = imm_i;
				end else if (funct3 == 3'b001) begin
					op = decode_pkg::op_fence_i; imm_sel = imm_i;
				end
			end
			maj_system: begin
				imm_sel = imm_i;
				case (funct3)
					3'b000: begin
						// ecall and ebreak differ only in imm[11:0], no immediate kept
						imm_sel = imm_none;
						if (ins[31:20] == 12'h000)
							op = decode_pkg::op_ecall;
						else if (ins[31:20] == 12'h001)
							op = decode_pkg::op_ebreak;
					end
					3'b001:  op = decode_pkg::op_csrrw;
					3'b010:  op = decode_pkg::op_csrrs;
					3'b011:  op = decode_pkg::op_csrrc;
					3'b101:  op = decode_pkg::op_csrrwi;
					3'b110:  op = decode_pkg::op_csrrsi;
					3'b111:  op = decode_pkg::op_csrrci;
					default: imm_sel = imm_none;
				endcase
			end
			default: op = decode_pkg::op_illegal;
		endcase
	end

	always_comb begin
		case (imm_sel)
			imm_i:   imm = {{52{ins[31]}}, ins[31:20]};
			imm_s:   imm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b:   imm = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_u:   imm = {{32{ins[31]}}, ins[31:12], 12'b0};
			imm_j:   imm = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			default: imm = 64'd0;
		endcase
	end

	assign micro_instr = '{
		op:    op,
		pc:    fd.pc,
		imm:   imm,
		shamt: ins[25:20],
		rd:    rd,
		rs1:   rs1,
		rs2:   rs2
	};

	// the only full check on the path
	assign push    = fd.valid & ~full;
	assign fd.push = push;

endmodule

// File: fetch_stage_reg.sv
// fetch to decode register
// one instruction slot with valid flag and fetch_ready back-pressure
`timescale 1ns/1ns

module fetch_stage_reg (
	input  logic        clk,
	input  logic        reset,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	input  logic [63:0] pc,
	output logic        fetch_ready,
	fetch_decode_if.producer fd
);

	logic        valid_q;
	logic [31:0] instr_q;
	logic [63:0] pc_q;
	logic        load;

	// slot is free when empty or draining this cycle
	assign fetch_ready = ~valid_q | fd.push;
	assign load = instr_valid & fetch_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (load) begin
			valid_q <= 1'b1;
		end else if (fd.push) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			instr_q <= instr;
			pc_q    <= pc;
		end
	end

	assign fd.instr = instr_q;
	assign fd.pc    = pc_q;
	assign fd.valid = valid_q;

endmodule

// File: fetch_decode_if.sv
// fetch register to decoder link
// instruction word, pc and valid level forward, push back
`timescale 1ns/1ns

interface fetch_decode_if;

	logic [31:0] instr;
	logic [63:0] pc;
	logic        valid;
	// instruction leaves the fetch register when valid and push are both high
	logic        push;

	modport producer (
		output instr,
		output pc,
		output valid,
		input  push
	);

	modport consumer (
		input  instr,
		input  pc,
		input  valid,
		output push
	);

endinterface

// File: decode_pkg.sv
// shared decode definitions
// micro-instruction opcode enum, micro-instruction struct and FIFO sizing
package decode_pkg;

	// one value per recognised RV64I / Zifencei / Zicsr instruction
	typedef enum logic [6:0] {
		op_illegal,
		op_lui, op_auipc, op_jal, op_jalr,
		// branches
		op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		// loads
		op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
		// stores
		op_sb, op_sh, op_sw, op_sd,
		// immediate alu and shifts
		op_addi, op_addiw, op_slti, op_sltiu, op_xori, op_ori, op_andi,
		op_slli, op_slliw, op_srli, op_srliw, op_srai, op_sraiw,
		// register alu
		op_add, op_addw, op_sub, op_subw, op_sll, op_sllw, op_slt, op_sltu,
		op_xor, op_srl, op_srlw, op_sra, op_sraw, op_or, op_and,
		// memory ordering and system
		op_fence, op_fence_i,
		op_ecall, op_ebreak,
		op_csrrw, op_csrrs, op_csrrc,
		op_csrrwi, op_csrrsi, op_csrrci
	} op_e;

	// compact micro-instruction handed to issue, 156 bits
	typedef struct packed {
		op_e         op;
		logic [63:0] pc;
		// sign-extended, zero for r-type and illegal words
		logic [63:0] imm;
		logic [5:0]  shamt;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
	} decode_info_t;

	// instruction FIFO sizing
	localparam int instr_fifo_depth = 4;
	localparam int instr_fifo_aw    = $clog2(instr_fifo_depth);

endpackage
